//--- logic/conv_pkg.sv
// Convolution accelerator shared definitions
package conv_pkg;

  // data lane and bus widths
  localparam int LANE_WIDTH = 16;
  localparam int ADDR_WIDTH = 58;
  localparam int MDATA_WIDTH = 14;
  localparam int COUNT_WIDTH = 32;

  typedef logic [LANE_WIDTH-1:0] lane_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [MDATA_WIDTH-1:0] mdata_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // tag bit 0 tells image (0) from kernel (1) lines
  localparam int TAG_KIND_BIT = 0;

  // job context layout
  localparam int CONTEXT_WIDTH = 256;
  localparam int CTX_FILTER_LSB = 0;
  localparam int CTX_DEST_LSB = 64;
  localparam int CTX_NUM_IN_LSB = 128;
  localparam int CTX_NUM_OUT_LSB = 160;

  // byte address to cache-line address
  localparam int LINE_OFFSET_BITS = 6;

  // read request phases
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_IMAGE,
    RD_KERNEL,
    RD_DONE
  } rd_state_t;

  // execution sequencer states
  typedef enum logic [1:0] {
    EX_IDLE,
    EX_RUN,
    EX_WAIT_SPACE
  } exec_state_t;

endpackage

//--- logic/buffer_if.sv
// Line buffer read interface
`timescale 1ns/1ps

interface buffer_if import conv_pkg::*; #(
  parameter int CACHE_WIDTH = 128,
  parameter int IMAGE_DEPTH_BITS = 4,
  parameter int KERNEL_DEPTH_BITS = 6
) ();

  logic [IMAGE_DEPTH_BITS-1:0] image_rd_addr;
  logic [KERNEL_DEPTH_BITS-1:0] kernel_rd_addr;
  logic [CACHE_WIDTH-1:0] image_line;
  logic [CACHE_WIDTH-1:0] kernel_line;
  // lines received so far in each buffer
  count_t image_fill;
  count_t kernel_fill;

  modport store (
    input image_rd_addr, kernel_rd_addr,
    output image_line, kernel_line, image_fill, kernel_fill
  );

  modport fetch (
    output image_rd_addr, kernel_rd_addr,
    input image_line, kernel_line, image_fill, kernel_fill
  );

endinterface

//--- logic/job_config.sv
// Job context capture
`timescale 1ns/1ps

module job_config import conv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic [CONTEXT_WIDTH-1:0] job_context,
  output logic                     job_start,
  output addr_t                    filter_line,
  output addr_t                    dest_line,
  output count_t                   num_in,
  output count_t                   num_out,
  output count_t                   kernel_lines
);

  count_t ctx_num_in;
  count_t ctx_num_out;

  assign ctx_num_in = job_context[CTX_NUM_IN_LSB +: COUNT_WIDTH];
  assign ctx_num_out = job_context[CTX_NUM_OUT_LSB +: COUNT_WIDTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      job_start <= 1'b0;
      filter_line <= '0;
      dest_line <= '0;
      num_in <= '0;
      num_out <= '0;
      kernel_lines <= '0;
    end else begin
      // fields become valid together with job_start
      job_start <= start;
      if (start) begin
        // addresses are kept in lines without the byte offset
        filter_line <= job_context[CTX_FILTER_LSB + LINE_OFFSET_BITS +: ADDR_WIDTH];
        dest_line <= job_context[CTX_DEST_LSB + LINE_OFFSET_BITS +: ADDR_WIDTH];
        num_in <= ctx_num_in;
        num_out <= ctx_num_out;
        // one kernel line per (output map, input map) pair
        kernel_lines <= ctx_num_in * ctx_num_out;
      end
    end
  end

endmodule

//--- logic/read_scheduler.sv
// Read request scheduler
`timescale 1ns/1ps

module read_scheduler import conv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   job_start,
  input  addr_t  filter_line,
  input  count_t num_in,
  input  count_t kernel_lines,
  input  logic   rd_req_almostfull,
  output addr_t  rd_req_addr,
  output mdata_t rd_req_mdata,
  output logic   rd_req_en
);

  localparam mdata_t TAG_IMAGE = '0;
  localparam mdata_t TAG_KERNEL = mdata_t'(1) << TAG_KIND_BIT;

  rd_state_t state;
  // next line to request and lines issued in this phase
  addr_t line_addr;
  count_t phase_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RD_IDLE;
      rd_req_en <= 1'b0;
      rd_req_addr <= '0;
      rd_req_mdata <= '0;
      line_addr <= '0;
      phase_cnt <= '0;
    end else if (job_start) begin
      // image lines start at line 0
      state <= RD_IMAGE;
      rd_req_en <= 1'b0;
      line_addr <= '0;
      phase_cnt <= '0;
    end else begin
      rd_req_en <= 1'b0;
      case (state)
        RD_IMAGE: begin
          if (!rd_req_almostfull) begin
            rd_req_en <= 1'b1;
            rd_req_addr <= line_addr;
            rd_req_mdata <= TAG_IMAGE;
            if (phase_cnt == num_in - 1) begin
              // switch straight to the kernels without an idle cycle
              state <= RD_KERNEL;
              line_addr <= filter_line;
              phase_cnt <= '0;
            end else begin
              line_addr <= line_addr + 1'b1;
              phase_cnt <= phase_cnt + 1'b1;
            end
          end
        end

        RD_KERNEL: begin
          if (!rd_req_almostfull) begin
            rd_req_en <= 1'b1;
            rd_req_addr <= line_addr;
            rd_req_mdata <= TAG_KERNEL;
            line_addr <= line_addr + 1'b1;
            phase_cnt <= phase_cnt + 1'b1;
            if (phase_cnt == kernel_lines - 1) begin
              state <= RD_DONE;
            end
          end
        end

        // idle and done wait for the next job
        default: begin
        end
      endcase
    end
  end

endmodule

//--- logic/line_buffers.sv
// Image and kernel line buffers
`timescale 1ns/1ps

module line_buffers import conv_pkg::*; #(
  parameter int CACHE_WIDTH = 128,
  parameter int IMAGE_DEPTH_BITS = 4,
  parameter int KERNEL_DEPTH_BITS = 6
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   job_start,
  input  logic                   rd_rsp_valid,
  input  mdata_t                 rd_rsp_mdata,
  input  logic [CACHE_WIDTH-1:0] rd_rsp_data,
  buffer_if.store                bufs
);

  localparam int IMAGE_DEPTH = 1 << IMAGE_DEPTH_BITS;
  localparam int KERNEL_DEPTH = 1 << KERNEL_DEPTH_BITS;

  logic [CACHE_WIDTH-1:0] image_mem [IMAGE_DEPTH];
  logic [CACHE_WIDTH-1:0] kernel_mem [KERNEL_DEPTH];

  logic image_we;
  logic kernel_we;

  // steer by the kind bit of the tag
  assign image_we = rd_rsp_valid && !rd_rsp_mdata[TAG_KIND_BIT];
  assign kernel_we = rd_rsp_valid && rd_rsp_mdata[TAG_KIND_BIT];

  // responses arrive in order per kind, so the fill count is the write slot
  always_ff @(posedge clk) begin
    if (image_we) begin
      image_mem[bufs.image_fill[IMAGE_DEPTH_BITS-1:0]] <= rd_rsp_data;
    end
    if (kernel_we) begin
      kernel_mem[bufs.kernel_fill[KERNEL_DEPTH_BITS-1:0]] <= rd_rsp_data;
    end
    // one cycle read latency
    bufs.image_line <= image_mem[bufs.image_rd_addr];
    bufs.kernel_line <= kernel_mem[bufs.kernel_rd_addr];
  end

  always_ff @(posedge clk) begin
    if (reset || job_start) begin
      bufs.image_fill <= '0;
      bufs.kernel_fill <= '0;
    end else begin
      if (image_we) begin
        bufs.image_fill <= bufs.image_fill + 1'b1;
      end
      if (kernel_we) begin
        bufs.kernel_fill <= bufs.kernel_fill + 1'b1;
      end
    end
  end

endmodule

//--- logic/exec_sequencer.sv
// Execution sequencer
`timescale 1ns/1ps

module exec_sequencer import conv_pkg::*; #(
  parameter int IMAGE_DEPTH_BITS = 4,
  parameter int KERNEL_DEPTH_BITS = 6
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   job_start,
  input  count_t num_in,
  input  count_t num_out,
  input  count_t kernel_lines,
  input  logic   has_space,
  buffer_if.fetch bufs,
  output logic   mac_valid,
  output logic   mac_first,
  output logic   mac_last
);

  exec_state_t state;
  // set by a new job until both buffers are loaded
  logic armed;
  logic loaded;
  logic issue;
  count_t map_cnt;
  count_t in_idx;
  count_t k_idx;

  assign loaded = (bufs.image_fill == num_in) && (bufs.kernel_fill == kernel_lines);
  assign issue = (state == EX_RUN);

  // image restarts per map while kernels are walked linearly
  assign bufs.image_rd_addr = in_idx[IMAGE_DEPTH_BITS-1:0];
  assign bufs.kernel_rd_addr = k_idx[KERNEL_DEPTH_BITS-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EX_IDLE;
      armed <= 1'b0;
      map_cnt <= '0;
      in_idx <= '0;
      k_idx <= '0;
      mac_valid <= 1'b0;
      mac_first <= 1'b0;
      mac_last <= 1'b0;
    end else begin
      // flags trail the address by the buffer read latency
      mac_valid <= issue;
      mac_first <= issue && (in_idx == '0);
      mac_last <= issue && (in_idx == num_in - 1);
      if (job_start) begin
        armed <= 1'b1;
        state <= EX_IDLE;
      end else begin
        case (state)
          EX_IDLE: begin
            if (armed && loaded) begin
              armed <= 1'b0;
              state <= EX_WAIT_SPACE;
              map_cnt <= '0;
              in_idx <= '0;
              k_idx <= '0;
            end
          end

          EX_WAIT_SPACE: begin
            // a map is only started with room for its result
            if (has_space) begin
              state <= EX_RUN;
            end
          end

          EX_RUN: begin
            k_idx <= k_idx + 1'b1;
            if (in_idx == num_in - 1) begin
              in_idx <= '0;
              map_cnt <= map_cnt + 1'b1;
              state <= (map_cnt == num_out - 1) ? EX_IDLE : EX_WAIT_SPACE;
            end else begin
              in_idx <= in_idx + 1'b1;
            end
          end

          default: begin
            state <= EX_IDLE;
          end
        endcase
      end
    end
  end

endmodule

//--- logic/mac_array.sv
// Lane-wise multiply-accumulate array
`timescale 1ns/1ps

module mac_array import conv_pkg::*; #(
  parameter int CACHE_WIDTH = 128
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mac_valid,
  input  logic                   mac_first,
  input  logic                   mac_last,
  input  logic [CACHE_WIDTH-1:0] image_line,
  input  logic [CACHE_WIDTH-1:0] kernel_line,
  output logic                   out_valid,
  output logic [CACHE_WIDTH-1:0] out_line
);

  localparam int LANES = CACHE_WIDTH / LANE_WIDTH;

  lane_t prod [LANES];
  lane_t acc [LANES];
  logic prod_valid;
  logic prod_first;
  logic prod_last;

  // lanes wrap modulo 2^16
  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      prod[l] <= image_line[l*LANE_WIDTH +: LANE_WIDTH] * kernel_line[l*LANE_WIDTH +: LANE_WIDTH];
      if (prod_valid) begin
        acc[l] <= prod_first ? prod[l] : acc[l] + prod[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      prod_first <= 1'b0;
      prod_last <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      prod_valid <= mac_valid;
      prod_first <= mac_first;
      prod_last <= mac_last;
      // sum is complete once the last product is in
      out_valid <= prod_valid && prod_last;
    end
  end

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      out_line[l*LANE_WIDTH +: LANE_WIDTH] = acc[l];
    end
  end

endmodule

//--- logic/write_queue.sv
// Output line queue and write requests
`timescale 1ns/1ps

module write_queue import conv_pkg::*; #(
  parameter int CACHE_WIDTH = 128,
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   job_start,
  input  addr_t                  dest_line,
  input  count_t                 num_out,
  input  logic                   in_valid,
  input  logic [CACHE_WIDTH-1:0] in_line,
  output logic                   has_space,
  input  logic                   wr_req_almostfull,
  output addr_t                  wr_req_addr,
  output mdata_t                 wr_req_mdata,
  output logic [CACHE_WIDTH-1:0] wr_req_data,
  output logic                   wr_req_en,
  output logic                   done
);

  localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_BITS;
  // four free entries cover the lines still in the MAC pipeline
  localparam logic [FIFO_DEPTH_BITS:0] MAX_FILL = (FIFO_DEPTH_BITS + 1)'(FIFO_DEPTH - 4);

  logic [CACHE_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [FIFO_DEPTH_BITS:0] count;
  count_t wr_idx;
  logic rd_fire;

  assign rd_fire = (count != '0) && !wr_req_almostfull;
  assign has_space = (count <= MAX_FILL);
  assign wr_req_mdata = '0;

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_line;
    end
    if (rd_fire) begin
      wr_req_data <= mem[rd_ptr];
      wr_req_addr <= dest_line + addr_t'(wr_idx);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      wr_req_en <= 1'b0;
      wr_idx <= '0;
      done <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({in_valid, rd_fire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      wr_req_en <= rd_fire;
      if (job_start) begin
        wr_idx <= '0;
        done <= 1'b0;
      end else begin
        if (rd_fire) begin
          wr_idx <= wr_idx + 1'b1;
        end
        // wr_idx already counts the request on the bus
        if (wr_req_en && wr_idx == num_out) begin
          done <= 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/conv_accel.sv
// Convolution layer accelerator top
`timescale 1ns/1ps

module conv_accel import conv_pkg::*; #(
  parameter int CACHE_WIDTH = 128,
  parameter int IMAGE_DEPTH_BITS = 4,
  parameter int KERNEL_DEPTH_BITS = 6,
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic [CONTEXT_WIDTH-1:0] job_context,
  output addr_t                    rd_req_addr,
  output mdata_t                   rd_req_mdata,
  output logic                     rd_req_en,
  input  logic                     rd_req_almostfull,
  input  logic                     rd_rsp_valid,
  input  mdata_t                   rd_rsp_mdata,
  input  logic [CACHE_WIDTH-1:0]   rd_rsp_data,
  output addr_t                    wr_req_addr,
  output mdata_t                   wr_req_mdata,
  output logic [CACHE_WIDTH-1:0]   wr_req_data,
  output logic                     wr_req_en,
  input  logic                     wr_req_almostfull,
  output logic                     done
);

  logic job_start;
  addr_t filter_line;
  addr_t dest_line;
  count_t num_in;
  count_t num_out;
  count_t kernel_lines;
  logic has_space;
  logic mac_valid;
  logic mac_first;
  logic mac_last;
  logic out_valid;
  logic [CACHE_WIDTH-1:0] out_line;

  buffer_if #(
    .CACHE_WIDTH(CACHE_WIDTH),
    .IMAGE_DEPTH_BITS(IMAGE_DEPTH_BITS),
    .KERNEL_DEPTH_BITS(KERNEL_DEPTH_BITS)
  ) bufs ();

  job_config u_job_config (
    .clk(clk), .reset(reset), .start(start), .job_context(job_context),
    .job_start(job_start), .filter_line(filter_line), .dest_line(dest_line),
    .num_in(num_in), .num_out(num_out), .kernel_lines(kernel_lines)
  );

  read_scheduler u_read_scheduler (
    .clk(clk), .reset(reset), .job_start(job_start), .filter_line(filter_line),
    .num_in(num_in), .kernel_lines(kernel_lines), .rd_req_almostfull(rd_req_almostfull),
    .rd_req_addr(rd_req_addr), .rd_req_mdata(rd_req_mdata), .rd_req_en(rd_req_en)
  );

  line_buffers #(
    .CACHE_WIDTH(CACHE_WIDTH),
    .IMAGE_DEPTH_BITS(IMAGE_DEPTH_BITS),
    .KERNEL_DEPTH_BITS(KERNEL_DEPTH_BITS)
  ) u_line_buffers (
    .clk(clk), .reset(reset), .job_start(job_start), .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_mdata(rd_rsp_mdata), .rd_rsp_data(rd_rsp_data), .bufs(bufs.store)
  );

  exec_sequencer #(
    .IMAGE_DEPTH_BITS(IMAGE_DEPTH_BITS),
    .KERNEL_DEPTH_BITS(KERNEL_DEPTH_BITS)
  ) u_exec_sequencer (
    .clk(clk), .reset(reset), .job_start(job_start), .num_in(num_in), .num_out(num_out),
    .kernel_lines(kernel_lines), .has_space(has_space), .bufs(bufs.fetch),
    .mac_valid(mac_valid), .mac_first(mac_first), .mac_last(mac_last)
  );

  mac_array #(.CACHE_WIDTH(CACHE_WIDTH)) u_mac_array (
    .clk(clk), .reset(reset), .mac_valid(mac_valid), .mac_first(mac_first),
    .mac_last(mac_last), .image_line(bufs.image_line), .kernel_line(bufs.kernel_line),
    .out_valid(out_valid), .out_line(out_line)
  );

  write_queue #(
    .CACHE_WIDTH(CACHE_WIDTH),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_write_queue (
    .clk(clk), .reset(reset), .job_start(job_start), .dest_line(dest_line),
    .num_out(num_out), .in_valid(out_valid), .in_line(out_line), .has_space(has_space),
    .wr_req_almostfull(wr_req_almostfull), .wr_req_addr(wr_req_addr),
    .wr_req_mdata(wr_req_mdata), .wr_req_data(wr_req_data), .wr_req_en(wr_req_en),
    .done(done)
  );

endmodule

//--- verification/conv_accel_tb.sv
// Convolution accelerator testbench
`timescale 1ns/1ps

module conv_accel_tb import conv_pkg::*; ();

  localparam int LINE_BITS = 128;
  localparam int LANES = LINE_BITS / LANE_WIDTH;
  localparam int MEM_LINES = 512;
  localparam int NUM_JOBS = 6;
  localparam int TIMEOUT_CYCLES = NUM_JOBS * 3000;

  logic clk;
  logic reset;
  logic start;
  logic [CONTEXT_WIDTH-1:0] job_context;
  addr_t rd_req_addr;
  mdata_t rd_req_mdata;
  logic rd_req_en;
  logic rd_req_almostfull;
  logic rd_rsp_valid;
  mdata_t rd_rsp_mdata;
  logic [LINE_BITS-1:0] rd_rsp_data;
  addr_t wr_req_addr;
  mdata_t wr_req_mdata;
  logic [LINE_BITS-1:0] wr_req_data;
  logic wr_req_en;
  logic wr_req_almostfull;
  logic done;

  // host memory and the job under test
  logic [LINE_BITS-1:0] host_mem [MEM_LINES];
  logic [LINE_BITS-1:0] expected_out [8];
  int job_num_in;
  int job_num_out;
  int job_kernel_lines;
  addr_t job_filter;
  addr_t job_dest;
  logic [31:0] lfsr = 32'hb4d23760;

  // requests waiting for a response, in issue order
  addr_t rsp_addr_q [$];
  mdata_t rsp_tag_q [$];
  int rsp_gap;
  logic gap_chosen = 1'b0;

  // monitor state
  int rd_count = 0;
  int wr_count = 0;
  int cycle_count = 0;
  int done_grace = 0;
  int jobs_done = 0;
  logic last_write_seen = 1'b0;
  logic done_seen = 1'b0;
  logic prev_rd_af = 1'b0;
  logic prev_wr_af = 1'b0;

  conv_accel UUT (
    .clk(clk), .reset(reset), .start(start), .job_context(job_context),
    .rd_req_addr(rd_req_addr), .rd_req_mdata(rd_req_mdata), .rd_req_en(rd_req_en),
    .rd_req_almostfull(rd_req_almostfull), .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_mdata(rd_rsp_mdata), .rd_rsp_data(rd_rsp_data),
    .wr_req_addr(wr_req_addr), .wr_req_mdata(wr_req_mdata), .wr_req_data(wr_req_data),
    .wr_req_en(wr_req_en), .wr_req_almostfull(wr_req_almostfull), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // each lane of output line o is the wrapped dot product over input maps
  function automatic logic [LINE_BITS-1:0] model_line(input int o);
    logic [LINE_BITS-1:0] line;
    logic [LINE_BITS-1:0] img;
    logic [LINE_BITS-1:0] ker;
    logic [31:0] prod;
    logic [15:0] sum;
    line = '0;
    for (int l = 0; l < LANES; l++) begin
      sum = '0;
      for (int d = 0; d < job_num_in; d++) begin
        img = host_mem[d];
        ker = host_mem[job_filter[8:0] + o * job_num_in + d];
        prod = img[l*16 +: 16] * ker[l*16 +: 16];
        sum = sum + prod[15:0];
      end
      line[l*16 +: 16] = sum;
    end
    return line;
  endfunction

  // one clock step with stimulus applied 1 ns after the edge
  task automatic next_cycle();
    logic [31:0] r;
    addr_t a;
    @(posedge clk);
    #1;
    r = take_bits(2);
    if (r[1:0] == 2'd0) begin
      rd_req_almostfull = !rd_req_almostfull;
    end
    r = take_bits(2);
    if (r[1:0] == 2'd0) begin
      wr_req_almostfull = !wr_req_almostfull;
    end
    rd_rsp_valid = 1'b0;
    if (rsp_addr_q.size() != 0) begin
      if (!gap_chosen) begin
        r = take_bits(2);
        rsp_gap = int'(r[1:0]);
        gap_chosen = 1'b1;
      end
      if (rsp_gap == 0) begin
        a = rsp_addr_q.pop_front();
        rd_rsp_mdata = rsp_tag_q.pop_front();
        rd_rsp_data = host_mem[a[8:0]];
        rd_rsp_valid = 1'b1;
        gap_chosen = 1'b0;
      end else begin
        rsp_gap = rsp_gap - 1;
      end
    end
  endtask

  task automatic check_read();
    addr_t exp_addr;
    mdata_t exp_tag;
    assert (rd_count < job_num_in + job_kernel_lines) else
      fail_run($sformatf("** Error at %0t: extra read request to line %0h", $time, rd_req_addr));
    if (rd_count < job_num_in) begin
      exp_addr = addr_t'(rd_count);
      exp_tag = '0;
    end else begin
      exp_addr = job_filter + addr_t'(rd_count - job_num_in);
      exp_tag = mdata_t'(1);
    end
    assert (rd_req_addr == exp_addr && rd_req_mdata == exp_tag) else
      fail_run($sformatf("** Error at %0t: read %0d got line %0h tag %0h, expected %0h tag %0h",
        $time, rd_count, rd_req_addr, rd_req_mdata, exp_addr, exp_tag));
    rsp_addr_q.push_back(rd_req_addr);
    rsp_tag_q.push_back(rd_req_mdata);
    rd_count = rd_count + 1;
  endtask

  task automatic check_write();
    assert (wr_count < job_num_out) else
      fail_run($sformatf("** Error at %0t: extra write request to line %0h", $time, wr_req_addr));
    assert (wr_req_addr == job_dest + addr_t'(wr_count) && wr_req_mdata == '0) else
      fail_run($sformatf("** Error at %0t: write %0d went to line %0h tag %0h, expected %0h",
        $time, wr_count, wr_req_addr, wr_req_mdata, job_dest + addr_t'(wr_count)));
    assert (wr_req_data == expected_out[wr_count]) else
      fail_run($sformatf("** Error at %0t: write %0d data %h, expected %h",
        $time, wr_count, wr_req_data, expected_out[wr_count]));
    wr_count = wr_count + 1;
    if (wr_count == job_num_out) begin
      last_write_seen = 1'b1;
    end
  endtask

  // the bus monitor samples what the DUT sampled at this edge
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout: %0d cycles passed and job %0d never finished",
        TIMEOUT_CYCLES, jobs_done));
    end
    if (!reset) begin
      assert (!(rd_req_en && prev_rd_af)) else
        fail_run($sformatf("** Error at %0t: read request right after almost-full", $time));
      assert (!(wr_req_en && prev_wr_af)) else
        fail_run($sformatf("** Error at %0t: write request right after almost-full", $time));
      if (start) begin
        rd_count = 0;
        wr_count = 0;
        last_write_seen = 1'b0;
        done_seen = 1'b0;
        done_grace = 2;
      end
      if (rd_req_en) begin
        check_read();
      end
      if (wr_req_en) begin
        check_write();
      end
      // done clears two edges after start is seen
      if (done_grace > 0) begin
        done_grace = done_grace - 1;
      end else if (done) begin
        assert (last_write_seen) else
          fail_run($sformatf("** Error at %0t: done high before the last write", $time));
        done_seen = 1'b1;
      end else begin
        assert (!done_seen) else
          fail_run($sformatf("** Error at %0t: done dropped before the next start", $time));
      end
    end
    prev_rd_af = rd_req_almostfull;
    prev_wr_af = wr_req_almostfull;
  end

  initial begin
    logic [31:0] r;
    reset = 1'b1;
    start = 1'b0;
    job_context = '0;
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_mdata = '0;
    rd_rsp_data = '0;
    for (int i = 0; i < MEM_LINES; i++) begin
      for (int w = 0; w < LINE_BITS / 32; w++) begin
        host_mem[i][w*32 +: 32] = take_bits(32);
      end
    end
    next_cycle();
    next_cycle();
    reset = 1'b0;

    for (int j = 0; j < NUM_JOBS; j++) begin
      r = take_bits(3);
      job_num_in = int'(r[2:0]) + 1;
      r = take_bits(3);
      job_num_out = int'(r[2:0]) + 1;
      job_kernel_lines = job_num_in * job_num_out;
      r = take_bits(8);
      job_filter = addr_t'(16 + r[7:0]);
      r = take_bits(20);
      job_dest = addr_t'(r[19:0]);
      for (int o = 0; o < job_num_out; o++) begin
        expected_out[o] = model_line(o);
      end
      job_context = '0;
      job_context[CTX_FILTER_LSB +: 64] = 64'(job_filter) << LINE_OFFSET_BITS;
      job_context[CTX_DEST_LSB +: 64] = 64'(job_dest) << LINE_OFFSET_BITS;
      job_context[CTX_NUM_IN_LSB +: 32] = job_num_in;
      job_context[CTX_NUM_OUT_LSB +: 32] = job_num_out;
      start = 1'b1;
      next_cycle();
      start = 1'b0;
      // done of the previous job clears first
      while (done) begin
        next_cycle();
      end
      while (!done) begin
        next_cycle();
      end
      assert (rd_count == job_num_in + job_kernel_lines && wr_count == job_num_out) else
        fail_run($sformatf("** Error at %0t: job %0d made %0d reads and %0d writes",
          $time, j, rd_count, wr_count));
      jobs_done = jobs_done + 1;
      // quiet gap catches stray writes
      for (int k = 0; k < 5; k++) begin
        next_cycle();
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- conv_accel.f
logic/conv_pkg.sv
logic/buffer_if.sv
logic/job_config.sv
logic/read_scheduler.sv
logic/line_buffers.sv
logic/exec_sequencer.sv
logic/mac_array.sv
logic/write_queue.sv
logic/conv_accel.sv
verification/conv_accel_tb.sv

//--- Makefile
# Verilator build for the convolution accelerator testbench

SRCS := $(shell cat conv_accel.f)

obj_dir/Vconv_accel_tb: conv_accel.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module conv_accel_tb \
		-f conv_accel.f -o Vconv_accel_tb

run: obj_dir/Vconv_accel_tb
	./obj_dir/Vconv_accel_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
